// ==== hw/rate_loop_cfg.svh ====
`ifndef RATE_LOOP_CFG_SVH
`define RATE_LOOP_CFG_SVH

// Datapath sizes
`define RL_NBEAMS        2
`define RL_THRESH_W      18
`define RL_COUNT_W       32
`define RL_ADR_W         22
`define RL_DAT_W         32

// Control loop settings
`define RL_START_THRESH  3500
`define RL_TARGET        100      // Triggers wanted per counting period
`define RL_MARGIN        10       // Dead band either side of the target
`define RL_KP            2        // Threshold step per round
`define RL_BOOT_CYCLES   31

// L1 trigger register map in word addresses
`define RL_ADR_CTRL      22'h000
`define RL_ADR_BEAM      22'h400  // Plus 4 per beam
`define RL_ADR_ARM       22'h800  // Plus 4 per beam
`define RL_CTRL_START    32'h1
`define RL_CTRL_APPLY    32'h2
`define RL_ARM_VAL       32'h1

// Readback address decode
`define RL_RB_CNT_BIT    10
`define RL_RB_THR_BIT    11
`define RL_RB_BEAM_HI    9
`define RL_RB_BEAM_LO    2

`endif

// ==== hw/rate_loop_pkg.sv ====
`include "rate_loop_cfg.svh"

package rate_loop_pkg;

    // One beam threshold as written to the trigger
    typedef logic [`RL_THRESH_W-1:0] thresh_t;

    // Triggers counted in one period
    typedef logic [`RL_COUNT_W-1:0] count_t;

    // Beam index, able to hold RL_NBEAMS itself
    typedef logic [$clog2(`RL_NBEAMS+1)-1:0] beam_t;

    // Wishbone bus fields
    typedef logic [`RL_ADR_W-1:0] wb_adr_t;
    typedef logic [`RL_DAT_W-1:0] wb_dat_t;

endpackage

// ==== hw/wb_master_port.sv ====
`timescale 1ns/100ps
`include "rate_loop_cfg.svh"

module wb_master_port (
    input  logic                   wb_clk_i,
    input  logic                   arst_n_i,
    input  logic                   req_i,
    input  logic                   we_i,
    input  rate_loop_pkg::wb_adr_t adr_i,
    input  rate_loop_pkg::wb_dat_t dat_i,
    output logic                   done_o,
    output rate_loop_pkg::wb_dat_t rdata_o,
    output logic                   wbm_cyc_o,
    output logic                   wbm_stb_o,
    output logic                   wbm_we_o,
    output rate_loop_pkg::wb_adr_t wbm_adr_o,
    output rate_loop_pkg::wb_dat_t wbm_dat_o,
    input  logic                   wbm_ack_i,
    input  rate_loop_pkg::wb_dat_t wbm_dat_i
);

    typedef enum logic {ST_SENDING, ST_WAITING} port_state_t;

    port_state_t state;

    assign wbm_cyc_o = (state == ST_WAITING);  // Bus held for the whole transfer
    assign wbm_stb_o = (state == ST_WAITING);

    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state  <= ST_SENDING;
            done_o <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state)
                ST_SENDING: if (req_i) state <= ST_WAITING;
                ST_WAITING: if (wbm_ack_i) begin
                    state  <= ST_SENDING;   // Drops cyc and stb after ack
                    done_o <= 1'b1;
                end
                default: state <= ST_SENDING;
            endcase
        end
    end

    // Request fields and read data
    always_ff @(posedge wb_clk_i) begin
        if (state == ST_SENDING && req_i) begin
            wbm_we_o  <= we_i;
            wbm_adr_o <= adr_i;
            wbm_dat_o <= dat_i;
        end
        if (state == ST_WAITING && wbm_ack_i) rdata_o <= wbm_dat_i;
    end

endmodule

// ==== hw/threshold_bank.sv ====
`timescale 1ns/100ps
`include "rate_loop_cfg.svh"

module threshold_bank (
    input  logic                                        wb_clk_i,
    input  logic                                        arst_n_i,
    input  rate_loop_pkg::beam_t                        beam_i,
    input  logic                                        count_we_i,
    input  rate_loop_pkg::count_t                       count_i,
    input  logic                                        calc_en_i,
    input  logic                                        commit_i,
    output rate_loop_pkg::count_t  [`RL_NBEAMS-1:0]     count_o,
    output rate_loop_pkg::thresh_t [`RL_NBEAMS-1:0]     next_thresh_o,
    output rate_loop_pkg::thresh_t [`RL_NBEAMS-1:0]     thresh_o
);

    localparam rate_loop_pkg::count_t HI_LIMIT =
        rate_loop_pkg::count_t'(`RL_TARGET + `RL_MARGIN);
    localparam rate_loop_pkg::count_t LO_LIMIT =
        rate_loop_pkg::count_t'(`RL_TARGET - `RL_MARGIN);
    localparam rate_loop_pkg::thresh_t GAIN = rate_loop_pkg::thresh_t'(`RL_KP);
    localparam rate_loop_pkg::thresh_t START_THRESH =
        rate_loop_pkg::thresh_t'(`RL_START_THRESH);

    rate_loop_pkg::count_t  [`RL_NBEAMS-1:0] count_q;   // Last measured counts
    rate_loop_pkg::thresh_t [`RL_NBEAMS-1:0] next_q;    // Proposed for the next apply
    rate_loop_pkg::thresh_t [`RL_NBEAMS-1:0] thresh_q;  // Currently applied in the trigger
    rate_loop_pkg::thresh_t                  calc_thresh;

    ////////////////////////////////////////////////////////////////////////////
    // Update rule for the selected beam

    always_comb begin
        if (count_q[beam_i] > HI_LIMIT) begin
            calc_thresh = thresh_q[beam_i] + GAIN;   // Rate too high so the threshold rises
        end else if (count_q[beam_i] < LO_LIMIT) begin
            calc_thresh = thresh_q[beam_i] - GAIN;   // Rate too low
        end else begin
            calc_thresh = thresh_q[beam_i];
        end
        // Wraps at the threshold width without clipping
    end

    ////////////////////////////////////////////////////////////////////////////
    // Register sets

    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int b = 0; b < `RL_NBEAMS; b++) begin
                count_q[b]  <= '0;
                next_q[b]   <= START_THRESH;
                thresh_q[b] <= START_THRESH;
            end
        end else begin
            if (count_we_i) count_q[beam_i] <= count_i;
            if (calc_en_i) next_q[beam_i] <= calc_thresh;
            if (commit_i) thresh_q <= next_q;    // All beams at once
        end
    end

    assign count_o       = count_q;
    assign next_thresh_o = next_q;
    assign thresh_o      = thresh_q;

endmodule

// ==== hw/rate_loop_seq.sv ====
`timescale 1ns/100ps
`include "rate_loop_cfg.svh"

module rate_loop_seq (
    input  logic                                        wb_clk_i,
    input  logic                                        arst_n_i,
    input  logic                                        done_i,
    input  rate_loop_pkg::wb_dat_t                      rdata_i,
    input  rate_loop_pkg::thresh_t [`RL_NBEAMS-1:0]     next_thresh_i,
    output logic                                        req_o,
    output logic                                        we_o,
    output rate_loop_pkg::wb_adr_t                      adr_o,
    output rate_loop_pkg::wb_dat_t                      dat_o,
    output rate_loop_pkg::beam_t                        beam_o,
    output logic                                        count_we_o,
    output logic                                        calc_en_o,
    output logic                                        commit_o
);

    localparam int BOOT_W = $clog2(`RL_BOOT_CYCLES + 1);
    localparam rate_loop_pkg::beam_t LAST_BEAM = rate_loop_pkg::beam_t'(`RL_NBEAMS - 1);

    typedef enum logic [2:0] {
        ST_BOOT, ST_START, ST_POLL, ST_READ, ST_CALC, ST_WRITE, ST_ARM, ST_APPLY
    } seq_state_t;

    seq_state_t             state;
    logic [BOOT_W-1:0]      boot_cnt;
    rate_loop_pkg::beam_t   beam_q;
    logic                   busy_q;     // A transfer is open at the port
    logic                   xfer_en;
    logic                   xfer_we;
    rate_loop_pkg::wb_adr_t xfer_adr;
    rate_loop_pkg::wb_dat_t xfer_dat;
    logic                   issue;

    function automatic rate_loop_pkg::wb_adr_t beam_adr(input rate_loop_pkg::wb_adr_t base,
                                                        input rate_loop_pkg::beam_t beam);
        beam_adr = base + (rate_loop_pkg::wb_adr_t'(beam) << 2);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Transfer wanted in each state

    always_comb begin
        xfer_en  = 1'b1;
        xfer_we  = 1'b1;
        xfer_adr = `RL_ADR_CTRL;
        xfer_dat = '0;
        case (state)
            ST_START: xfer_dat = `RL_CTRL_START;
            ST_POLL:  xfer_we  = 1'b0;              // Status read
            ST_READ: begin
                xfer_we  = 1'b0;
                xfer_adr = beam_adr(`RL_ADR_BEAM, beam_q);
            end
            ST_WRITE: begin
                xfer_adr = beam_adr(`RL_ADR_BEAM, beam_q);
                xfer_dat = rate_loop_pkg::wb_dat_t'(next_thresh_i[beam_q]);
            end
            ST_ARM: begin
                xfer_adr = beam_adr(`RL_ADR_ARM, beam_q);
                xfer_dat = `RL_ARM_VAL;
            end
            ST_APPLY: xfer_dat = `RL_CTRL_APPLY;
            default:  xfer_en  = 1'b0;              // Boot and calculation stay off the bus
        endcase
    end

    assign issue = xfer_en && !busy_q;

    always_ff @(posedge wb_clk_i) begin
        if (issue) begin
            we_o  <= xfer_we;
            adr_o <= xfer_adr;
            dat_o <= xfer_dat;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Round FSM

    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state    <= ST_BOOT;
            boot_cnt <= BOOT_W'(`RL_BOOT_CYCLES);
            beam_q   <= '0;
            busy_q   <= 1'b0;
            req_o    <= 1'b0;
        end else begin
            req_o <= issue;                         // One cycle per transfer
            if (issue) busy_q <= 1'b1;
            if (done_i) busy_q <= 1'b0;
            case (state)
                ST_BOOT: begin
                    if (boot_cnt != '0) boot_cnt <= boot_cnt - 1'b1;
                    else state <= ST_WRITE;         // Load starting thresholds first
                end
                ST_START: if (done_i) state <= ST_POLL;
                ST_POLL:  if (done_i && rdata_i[0]) state <= ST_READ;   // Else ask again
                ST_READ, ST_WRITE, ST_ARM: begin
                    if (done_i) begin
                        if (beam_q == LAST_BEAM) begin
                            beam_q <= '0;
                            case (state)
                                ST_READ:  state <= ST_CALC;
                                ST_WRITE: state <= ST_ARM;
                                default:  state <= ST_APPLY;
                            endcase
                        end else begin
                            beam_q <= beam_q + 1'b1;
                        end
                    end
                end
                ST_CALC: begin
                    if (beam_q == LAST_BEAM) begin
                        beam_q <= '0;
                        state  <= ST_WRITE;
                    end else begin
                        beam_q <= beam_q + 1'b1;
                    end
                end
                ST_APPLY: if (done_i) state <= ST_START;
                default:  state <= ST_BOOT;
            endcase
        end
    end

    assign beam_o     = beam_q;
    assign count_we_o = (state == ST_READ) && done_i;   // Count arrives with done
    assign calc_en_o  = (state == ST_CALC);
    assign commit_o   = (state == ST_APPLY) && done_i;

endmodule

// ==== hw/csr_readback.sv ====
`timescale 1ns/100ps
`include "rate_loop_cfg.svh"

module csr_readback (
    input  logic                                        wb_clk_i,
    input  logic                                        arst_n_i,
    input  logic                                        wbs_cyc_i,
    input  logic                                        wbs_stb_i,
    input  logic                                        wbs_we_i,
    input  rate_loop_pkg::wb_adr_t                      wbs_adr_i,
    input  rate_loop_pkg::wb_dat_t                      wbs_dat_i,
    input  rate_loop_pkg::count_t  [`RL_NBEAMS-1:0]     count_i,
    input  rate_loop_pkg::thresh_t [`RL_NBEAMS-1:0]     thresh_i,
    output logic                                        wbs_ack_o,
    output rate_loop_pkg::wb_dat_t                      wbs_dat_o
);

    typedef enum logic [1:0] {ST_IDLE, ST_WRITE, ST_READ, ST_ACK} csr_state_t;

    csr_state_t             state;
    logic [`RL_RB_BEAM_HI-`RL_RB_BEAM_LO:0] rb_beam;
    rate_loop_pkg::wb_dat_t rd_word;

    assign rb_beam = wbs_adr_i[`RL_RB_BEAM_HI:`RL_RB_BEAM_LO];

    // Select the readback word
    always_comb begin
        rd_word = rate_loop_pkg::wb_dat_t'(`RL_KP);
        if (wbs_adr_i[`RL_RB_CNT_BIT]) begin
            rd_word = (rb_beam < `RL_NBEAMS) ? count_i[rb_beam] : '0;
        end else if (wbs_adr_i[`RL_RB_THR_BIT]) begin
            rd_word = (rb_beam < `RL_NBEAMS) ?
                      rate_loop_pkg::wb_dat_t'(thresh_i[rb_beam]) : '0;
        end
    end

    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE:  if (wbs_cyc_i && wbs_stb_i) state <= wbs_we_i ? ST_WRITE : ST_READ;
                ST_WRITE: state <= ST_ACK;      // Nothing here is writable
                ST_READ:  state <= ST_ACK;
                default:  state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (state == ST_READ) wbs_dat_o <= rd_word;
    end

    assign wbs_ack_o = (state == ST_ACK);

endmodule

// ==== hw/rate_loop_top.sv ====
`timescale 1ns/100ps
`include "rate_loop_cfg.svh"

module rate_loop_top (
    input  logic                   wb_clk_i,
    input  logic                   arst_n_i,
    // Software readback target
    input  logic                   wbs_cyc_i,
    input  logic                   wbs_stb_i,
    input  logic                   wbs_we_i,
    input  rate_loop_pkg::wb_adr_t wbs_adr_i,
    input  rate_loop_pkg::wb_dat_t wbs_dat_i,
    output logic                   wbs_ack_o,
    output rate_loop_pkg::wb_dat_t wbs_dat_o,
    // L1 trigger master
    output logic                   wbm_cyc_o,
    output logic                   wbm_stb_o,
    output logic                   wbm_we_o,
    output rate_loop_pkg::wb_adr_t wbm_adr_o,
    output rate_loop_pkg::wb_dat_t wbm_dat_o,
    input  logic                   wbm_ack_i,
    input  rate_loop_pkg::wb_dat_t wbm_dat_i
);

    logic                                    seq_req;
    logic                                    seq_we;
    rate_loop_pkg::wb_adr_t                  seq_adr;
    rate_loop_pkg::wb_dat_t                  seq_dat;
    logic                                    port_done;
    rate_loop_pkg::wb_dat_t                  port_rdata;   // Also the count being stored
    rate_loop_pkg::beam_t                    beam;
    logic                                    count_we;
    logic                                    calc_en;
    logic                                    commit;
    rate_loop_pkg::count_t  [`RL_NBEAMS-1:0] count;
    rate_loop_pkg::thresh_t [`RL_NBEAMS-1:0] next_thresh;
    rate_loop_pkg::thresh_t [`RL_NBEAMS-1:0] thresh;

    wb_master_port u_port (
        .wb_clk_i, .arst_n_i,
        .req_i(seq_req), .we_i(seq_we), .adr_i(seq_adr), .dat_i(seq_dat),
        .done_o(port_done), .rdata_o(port_rdata),
        .wbm_cyc_o, .wbm_stb_o, .wbm_we_o, .wbm_adr_o, .wbm_dat_o,
        .wbm_ack_i, .wbm_dat_i
    );

    threshold_bank u_bank (
        .wb_clk_i, .arst_n_i,
        .beam_i(beam), .count_we_i(count_we), .count_i(port_rdata),
        .calc_en_i(calc_en), .commit_i(commit),
        .count_o(count), .next_thresh_o(next_thresh), .thresh_o(thresh)
    );

    rate_loop_seq u_seq (
        .wb_clk_i, .arst_n_i,
        .done_i(port_done), .rdata_i(port_rdata), .next_thresh_i(next_thresh),
        .req_o(seq_req), .we_o(seq_we), .adr_o(seq_adr), .dat_o(seq_dat),
        .beam_o(beam), .count_we_o(count_we), .calc_en_o(calc_en), .commit_o(commit)
    );

    csr_readback u_csr (
        .wb_clk_i, .arst_n_i,
        .wbs_cyc_i, .wbs_stb_i, .wbs_we_i, .wbs_adr_i, .wbs_dat_i,
        .count_i(count), .thresh_i(thresh),
        .wbs_ack_o, .wbs_dat_o
    );

endmodule

// ==== tb/l1_trigger_model.sv ====
`timescale 1ns/100ps
`include "rate_loop_cfg.svh"

module l1_trigger_model (
    input  logic                   wb_clk_i,
    input  logic                   wbm_cyc_i,
    input  logic                   wbm_stb_i,
    input  logic                   wbm_we_i,
    input  rate_loop_pkg::wb_adr_t wbm_adr_i,
    input  rate_loop_pkg::wb_dat_t wbm_dat_i,
    output logic                   wbm_ack_o,
    output rate_loop_pkg::wb_dat_t wbm_dat_o
);

    localparam int LOG_DEPTH = 2048;

    rate_loop_pkg::count_t  count_tbl [`RL_NBEAMS];  // Counts served on beam reads
    logic                   log_we    [LOG_DEPTH];
    rate_loop_pkg::wb_adr_t log_adr   [LOG_DEPTH];
    rate_loop_pkg::wb_dat_t log_dat   [LOG_DEPTH];   // Write data or returned read data
    int                     log_n;
    int                     apply_n;
    int                     poll_init;               // Not-done answers after the last start
    int                     poll_left;
    logic                   paused;                  // Set by each apply and cleared by the testbench
    logic [31:0]            lfsr_q;

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v = (v << 1) | int'(lfsr_q[0]);
        end
        return v;
    endfunction

    task automatic serve_transfer();
        rate_loop_pkg::wb_dat_t rd;
        int                     beam;
        rd = '0;
        beam = int'((wbm_adr_i >> 2) & 22'hff);
        if (wbm_we_i) begin
            if (wbm_adr_i == `RL_ADR_CTRL && wbm_dat_i == `RL_CTRL_START) begin
                poll_init = 1 + rand_bits(2);
                poll_left = poll_init;
            end
            if (wbm_adr_i == `RL_ADR_CTRL && wbm_dat_i == `RL_CTRL_APPLY) begin
                apply_n++;
                paused = 1'b1;
            end
        end else if (wbm_adr_i == `RL_ADR_CTRL) begin
            if (poll_left > 0) poll_left--;
            else rd = 32'h1;                         // Period done
        end else if (beam < `RL_NBEAMS) begin
            rd = count_tbl[beam];
        end
        if (log_n < LOG_DEPTH) begin
            log_we[log_n]  = wbm_we_i;
            log_adr[log_n] = wbm_adr_i;
            log_dat[log_n] = wbm_we_i ? wbm_dat_i : rd;
            log_n++;
        end
        wbm_dat_o = rd;
    endtask

    initial begin
        int delay;
        lfsr_q    = 32'h5173;
        wbm_ack_o = 1'b0;
        wbm_dat_o = '0;
        log_n     = 0;
        apply_n   = 0;
        poll_init = 0;
        poll_left = 0;
        paused    = 1'b0;
        for (int b = 0; b < `RL_NBEAMS; b++) count_tbl[b] = '0;
        forever begin
            @(posedge wb_clk_i);
            #1;
            if (wbm_cyc_i && wbm_stb_i) begin
                while (paused) begin
                    @(posedge wb_clk_i);
                    #1;
                end
                delay = rand_bits(3);               // 0 to 7 wait cycles
                repeat (delay) begin
                    @(posedge wb_clk_i);
                    #1;
                end
                serve_transfer();
                wbm_ack_o = 1'b1;
                @(posedge wb_clk_i);
                #1;
                wbm_ack_o = 1'b0;
            end
        end
    end

endmodule

// ==== tb/tb_rate_loop.sv ====
`timescale 1ns/100ps
`include "rate_loop_cfg.svh"

module tb_rate_loop;

    localparam int N_ROUNDS    = 24;
    localparam int CYCLE_LIMIT = N_ROUNDS * (`RL_BOOT_CYCLES + 40 * 10) + 3000;
    localparam rate_loop_pkg::wb_adr_t RB_GAIN = 22'h000;
    localparam rate_loop_pkg::wb_adr_t RB_CNT  = 22'h400;  // Plus 4 per beam
    localparam rate_loop_pkg::wb_adr_t RB_THR  = 22'h800;

    logic                   wb_clk_i;
    logic                   arst_n_i;
    logic                   wbs_cyc_i;
    logic                   wbs_stb_i;
    logic                   wbs_we_i;
    rate_loop_pkg::wb_adr_t wbs_adr_i;
    rate_loop_pkg::wb_dat_t wbs_dat_i;
    logic                   wbs_ack_o;
    rate_loop_pkg::wb_dat_t wbs_dat_o;
    logic                   wbm_cyc_o;
    logic                   wbm_stb_o;
    logic                   wbm_we_o;
    rate_loop_pkg::wb_adr_t wbm_adr_o;
    rate_loop_pkg::wb_dat_t wbm_dat_o;
    logic                   wbm_ack_i;
    rate_loop_pkg::wb_dat_t wbm_dat_i;

    rate_loop_pkg::thresh_t exp_thr [`RL_NBEAMS];    // Applied thresholds per reference
    rate_loop_pkg::count_t  exp_cnt [`RL_NBEAMS];
    int errors       = 0;
    int test_errors  = 0;
    int tests_run    = 0;
    int tests_failed = 0;
    int cycles       = 0;

    rate_loop_top dut_i (
        .wb_clk_i, .arst_n_i,
        .wbs_cyc_i, .wbs_stb_i, .wbs_we_i, .wbs_adr_i, .wbs_dat_i, .wbs_ack_o, .wbs_dat_o,
        .wbm_cyc_o, .wbm_stb_o, .wbm_we_o, .wbm_adr_o, .wbm_dat_o, .wbm_ack_i, .wbm_dat_i
    );

    l1_trigger_model model_i (
        .wb_clk_i,
        .wbm_cyc_i(wbm_cyc_o), .wbm_stb_i(wbm_stb_o), .wbm_we_i(wbm_we_o),
        .wbm_adr_i(wbm_adr_o), .wbm_dat_i(wbm_dat_o),
        .wbm_ack_o(wbm_ack_i), .wbm_dat_o(wbm_dat_i)
    );

    initial begin
        wb_clk_i = 1'b0;
        forever #50 wb_clk_i = ~wb_clk_i;
    end

    initial begin
        while (cycles < CYCLE_LIMIT) begin
            @(posedge wb_clk_i);
            cycles++;
        end
        $display("timeout: no progress after %0d cycles", cycles);
        $display("RESULT: FAIL");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference model and compare tasks

    function automatic rate_loop_pkg::thresh_t next_threshold(input rate_loop_pkg::count_t count,
                                                              input rate_loop_pkg::thresh_t thr);
        if (count > `RL_TARGET + `RL_MARGIN) return thr + `RL_KP;
        if (count < `RL_TARGET - `RL_MARGIN) return thr - `RL_KP;   // Wraps at the threshold width
        return thr;
    endfunction

    task automatic note_error();
        errors++;
        test_errors++;
    endtask

    task automatic check_thresh(input string name, input rate_loop_pkg::thresh_t got,
                                input rate_loop_pkg::thresh_t exp);
        if (got !== exp) begin
            $display("mismatch at %0d ns: %s got %0d expected %0d", $time, name, got, exp);
            note_error();
        end
    endtask

    task automatic check_count(input string name, input rate_loop_pkg::count_t got,
                               input rate_loop_pkg::count_t exp);
        if (got !== exp) begin
            $display("mismatch at %0d ns: %s got %0d expected %0d", $time, name, got, exp);
            note_error();
        end
    endtask

    task automatic check_word(input string name, input rate_loop_pkg::wb_dat_t got,
                              input rate_loop_pkg::wb_dat_t exp);
        if (got !== exp) begin
            $display("mismatch at %0d ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
            note_error();
        end
    endtask

    task automatic check_entry(inout int idx, input logic we, input rate_loop_pkg::wb_adr_t adr,
                               input rate_loop_pkg::wb_dat_t dat);
        if (idx >= model_i.log_n) begin
            $display("error at %0d ns: trigger transfer log ends before entry %0d", $time, idx);
            note_error();
        end else begin
            check_word($sformatf("log[%0d].we", idx), model_i.log_we[idx], we);
            check_word($sformatf("log[%0d].adr", idx), model_i.log_adr[idx], adr);
            check_word($sformatf("log[%0d].dat", idx), model_i.log_dat[idx], dat);
        end
        idx++;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Bus helpers

    task automatic csr_access(input logic we, input rate_loop_pkg::wb_adr_t adr,
                              input rate_loop_pkg::wb_dat_t wdat,
                              output rate_loop_pkg::wb_dat_t rdat);
        @(posedge wb_clk_i);
        #1;
        wbs_cyc_i = 1'b1;
        wbs_stb_i = 1'b1;
        wbs_we_i  = we;
        wbs_adr_i = adr;
        wbs_dat_i = wdat;
        do begin
            @(posedge wb_clk_i);
            #1;
        end while (!wbs_ack_o);
        rdat      = wbs_dat_o;
        wbs_cyc_i = 1'b0;                           // Dropped inside the ack cycle
        wbs_stb_i = 1'b0;
        wbs_we_i  = 1'b0;
    endtask

    task automatic readback_check();
        rate_loop_pkg::wb_dat_t d;
        for (int b = 0; b < `RL_NBEAMS; b++) begin
            csr_access(1'b0, RB_CNT + 4 * b, '0, d);
            check_count($sformatf("readback count[%0d]", b), d, exp_cnt[b]);
            csr_access(1'b0, RB_THR + 4 * b, '0, d);
            check_thresh($sformatf("readback thresh[%0d]", b), d[`RL_THRESH_W-1:0], exp_thr[b]);
            check_word($sformatf("readback thresh[%0d] upper bits", b),
                       d >> `RL_THRESH_W, '0);
        end
        csr_access(1'b0, RB_GAIN, '0, d);
        check_word("readback gain", d, `RL_KP);
    endtask

    // Applied threshold of one beam against a fixed value
    task automatic applied_check(input int b, input rate_loop_pkg::thresh_t exp);
        rate_loop_pkg::wb_dat_t d;
        csr_access(1'b0, RB_THR + 4 * b, '0, d);
        check_thresh($sformatf("applied thresh[%0d]", b), d[`RL_THRESH_W-1:0], exp);
    endtask

    task automatic wait_apply(input int target);
        while (model_i.apply_n < target) begin
            @(posedge wb_clk_i);
            #1;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %-26s ok", name);
        end else begin
            $display("test %-26s failed with %0d errors", name, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    // Serve one round of counts and check the whole round of transfers
    task automatic run_round(input rate_loop_pkg::count_t c0, input rate_loop_pkg::count_t c1);
        rate_loop_pkg::count_t cnt [`RL_NBEAMS];
        int idx;
        int polls;
        int target;
        cnt[0] = c0;
        cnt[1] = c1;
        for (int b = 0; b < `RL_NBEAMS; b++) model_i.count_tbl[b] = cnt[b];
        idx    = model_i.log_n;
        target = model_i.apply_n + 1;
        model_i.paused = 1'b0;
        wait_apply(target);
        check_entry(idx, 1'b1, `RL_ADR_CTRL, `RL_CTRL_START);
        polls = 0;
        while (idx < model_i.log_n && !model_i.log_we[idx] &&
               model_i.log_adr[idx] == `RL_ADR_CTRL && model_i.log_dat[idx] == '0) begin
            idx++;
            polls++;
        end
        check_word("not-done status reads", polls, model_i.poll_init);
        check_entry(idx, 1'b0, `RL_ADR_CTRL, 32'h1);   // Done answer comes before the count reads
        for (int b = 0; b < `RL_NBEAMS; b++) begin
            check_entry(idx, 1'b0, `RL_ADR_BEAM + 4 * b, cnt[b]);
        end
        for (int b = 0; b < `RL_NBEAMS; b++) begin
            exp_thr[b] = next_threshold(cnt[b], exp_thr[b]);
            exp_cnt[b] = cnt[b];
            check_entry(idx, 1'b1, `RL_ADR_BEAM + 4 * b, 32'(exp_thr[b]));
        end
        for (int b = 0; b < `RL_NBEAMS; b++) begin
            check_entry(idx, 1'b1, `RL_ADR_ARM + 4 * b, `RL_ARM_VAL);
        end
        check_entry(idx, 1'b1, `RL_ADR_CTRL, `RL_CTRL_APPLY);
        check_word("log length after apply", idx, model_i.log_n);
        readback_check();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence

    initial begin
        rate_loop_pkg::wb_dat_t d;
        int idx;
        arst_n_i  = 1'b0;
        wbs_cyc_i = 1'b0;
        wbs_stb_i = 1'b0;
        wbs_we_i  = 1'b0;
        wbs_adr_i = '0;
        wbs_dat_i = '0;
        for (int b = 0; b < `RL_NBEAMS; b++) begin
            exp_thr[b] = `RL_START_THRESH;
            exp_cnt[b] = '0;
        end
        repeat (16) @(posedge wb_clk_i);
        #1;
        arst_n_i = 1'b1;

        wait_apply(1);                              // Boot load ends with the first apply
        idx = 0;
        for (int b = 0; b < `RL_NBEAMS; b++) begin
            check_entry(idx, 1'b1, `RL_ADR_BEAM + 4 * b, `RL_START_THRESH);
        end
        for (int b = 0; b < `RL_NBEAMS; b++) begin
            check_entry(idx, 1'b1, `RL_ADR_ARM + 4 * b, `RL_ARM_VAL);
        end
        check_entry(idx, 1'b1, `RL_ADR_CTRL, `RL_CTRL_APPLY);
        check_word("boot log length", idx, model_i.log_n);
        readback_check();
        finish_test("boot sequence");

        run_round(150, 40);
        applied_check(0, 3502);                     // One gain step up from the start
        applied_check(1, 3498);
        finish_test("rate-driven update");

        run_round(90, 110);
        run_round(100, 100);
        applied_check(0, 3502);                     // Inside the dead band nothing moves
        applied_check(1, 3498);
        finish_test("dead band");

        run_round(120, 80);
        finish_test("polling");

        for (int r = 0; r < 20; r++) begin
            run_round(70 + model_i.rand_bits(6), 70 + model_i.rand_bits(6));
        end
        finish_test("random sustained operation");

        csr_access(1'b1, RB_THR, 32'h1234, d);     // Writes are acked and dropped
        csr_access(1'b1, RB_GAIN, 32'h7, d);
        csr_access(1'b1, RB_CNT + 4, 32'h55, d);
        readback_check();
        finish_test("ignored writes");

        $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+hw
hw/rate_loop_pkg.sv
hw/wb_master_port.sv
hw/threshold_bank.sv
hw/rate_loop_seq.sv
hw/csr_readback.sv
hw/rate_loop_top.sv
tb/l1_trigger_model.sv
tb/tb_rate_loop.sv
